//--- sim.f
hw/cpuPkg.sv
hw/cuPkg.sv
hw/cuSequencer.sv
hw/opDecoder.sv
hw/ctrlWordGen.sv
hw/controlUnit.sv
dv/cuChecks.sv
dv/cuTb.sv

//--- Bender.yml
package:
  name: control_unit

sources:
  - files:
      - hw/cpuPkg.sv
      - hw/cuPkg.sv
      - hw/cuSequencer.sv
      - hw/opDecoder.sv
      - hw/ctrlWordGen.sv
      - hw/controlUnit.sv
  - target: test
    files:
      - dv/cuChecks.sv
      - dv/cuTb.sv

//--- dv/cuTb.sv
`timescale 1ns/1ps

module cuTb;

	typedef struct packed {
		cpuPkg::opcode_t op;
		logic sign; // Flag bit 7 for this instruction
	} stim_t;

	logic clk;
	logic rst;
	cpuPkg::opcode_t opcode;
	logic opAck;
	cpuPkg::flags_t flags;
	cpuPkg::ctrlWord_t ctrl;
	cpuPkg::aluFn_t aluFn;
	logic opReq;
	logic halted;
	int errCount;
	int wordCount;
	int seed;
	int stimCount;
	stim_t stimList[$];

	controlUnit controlUnit_i (
		.clk    (clk),
		.rst    (rst),
		.opcode (opcode),
		.opAck  (opAck),
		.flags  (flags),
		.ctrl   (ctrl),
		.aluFn  (aluFn),
		.opReq  (opReq),
		.halted (halted)
	);

	cuChecks cuChecks_i (
		.clk       (clk),
		.rst       (rst),
		.opcode    (opcode),
		.opAck     (opAck),
		.flags     (flags),
		.ctrl      (ctrl),
		.aluFn     (aluFn),
		.opReq     (opReq),
		.halted    (halted),
		.errCount  (errCount),
		.wordCount (wordCount)
	);

	always #20 clk = ~clk;

	task automatic addStim(input cpuPkg::opcode_t op, input logic sign);
		stimList.push_back('{op, sign});
	endtask

	// Answers one opReq with the given opcode
	task automatic sendOpcode(input stim_t s);
		int delay;
		do
			@(posedge clk);
		while (!opReq);
		flags <= {s.sign, 7'($random(seed))}; // Low flag bits are ignored
		delay = $unsigned($random(seed)) % 4;
		repeat (delay) @(posedge clk);
		opcode <= s.op;
		opAck <= 1'b1;
		do
			@(posedge clk);
		while (opReq);
		opAck <= 1'b0;
	endtask

	initial
	begin
		clk = 1'b0;
		rst = 1'b1;
		opcode = '0;
		opAck = 1'b0;
		flags = '0;
		seed = 1313;
		addStim(cpuPkg::opStore, 1'b0);
		addStim(cpuPkg::opLoad, 1'b1);
		addStim(cpuPkg::opAdd, 1'b0);
		addStim(cpuPkg::opSub, 1'b0);
		addStim(cpuPkg::opMul, 1'b1);
		addStim(cpuPkg::opDiv, 1'b0);
		addStim(cpuPkg::opAnd, 1'b0);
		addStim(cpuPkg::opOr, 1'b1);
		addStim(cpuPkg::opNotMem, 1'b0);
		addStim(cpuPkg::opShr, 1'b0);
		addStim(cpuPkg::opShl, 1'b1);
		addStim(cpuPkg::opNotAcc, 1'b0);
		addStim(cpuPkg::opJump, 1'b0);
		addStim(cpuPkg::opJumpIfPos, 1'b0); // Taken
		addStim(cpuPkg::opJumpIfPos, 1'b1); // Not taken
		addStim(8'h3C, 1'b0); // Undefined code
		addStim(cpuPkg::opHalt, 1'b0);
		stimCount = stimList.size();
		repeat (3) @(posedge clk);
		rst <= 1'b0;
		foreach (stimList[i])
			sendOpcode(stimList[i]);
		do
			@(posedge clk);
		while (!halted);
		repeat (5) @(posedge clk);
		$display("Instructions: %0d, execute words compared: %0d, errors: %0d",
			stimCount, wordCount, errCount);
		if (errCount == 0)
			$display("ALL CHECKS PASSED");
		else
			$display("CHECKS FAILED");
		$finish;
	end

	// Watchdog, 20 cycles per instruction
	initial
	begin
		wait (stimCount != 0);
		repeat (stimCount * 20) @(posedge clk);
		$display("Timeout: the control unit did not reach halt in time");
		$display("CHECKS FAILED");
		$finish;
	end

endmodule

//--- dv/cuChecks.sv
`timescale 1ns/1ps

module cuChecks (
	input  logic              clk,
	input  logic              rst,
	input  cpuPkg::opcode_t   opcode,
	input  logic              opAck,
	input  cpuPkg::flags_t    flags,
	input  cpuPkg::ctrlWord_t ctrl,
	input  cpuPkg::aluFn_t    aluFn,
	input  logic              opReq,
	input  logic              halted,
	output int                errCount,
	output int                wordCount
);

	typedef struct packed {
		cpuPkg::ctrlWord_t ctrl;
		cpuPkg::aluFn_t fn;
	} expWord_t;

	expWord_t expQ[$]; // Execute words still to come
	expWord_t want;
	cpuPkg::ctrlWord_t prevCtrl;
	logic prevOpReq;
	logic prevHalted;
	logic prevRst;
	logic seenHalt;

	function automatic cpuPkg::ctrlWord_t ctrlBit(input int idx);
		return cpuPkg::ctrlWord_t'(1) << idx;
	endfunction

	// 0 MAR from PC, 1 read and PC increment, 2 IR from MBR, 3 IR to CU
	function automatic cpuPkg::ctrlWord_t fetchWord(input int n);
		case (n)
			0:       return ctrlBit(cpuPkg::cMarFromPc);
			1:       return ctrlBit(cpuPkg::cMbrRead) | ctrlBit(cpuPkg::cMemToMbr)
				| ctrlBit(cpuPkg::cPcInc);
			2:       return ctrlBit(cpuPkg::cIrFromMbr);
			default: return ctrlBit(cpuPkg::cIrToCu);
		endcase
	endfunction

	task automatic failValue(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		errCount++;
		$display("[FAIL] %0t ns %s expected %h got %h", $time, name, expected, actual);
	endtask

	task automatic failMsg(input string what);
		errCount++;
		$display("[FAIL] %0t ns: %s", $time, what);
	endtask

	task automatic expectExec(input cpuPkg::opcode_t op, input logic sign);
		cpuPkg::aluFn_t fn;
		cpuPkg::ctrlWord_t last;
		fn = '0;
		case (op)
			cpuPkg::opAdd:    fn[cpuPkg::fnAdd] = 1'b1;
			cpuPkg::opSub:    fn[cpuPkg::fnSub] = 1'b1;
			cpuPkg::opMul:    fn[cpuPkg::fnMul] = 1'b1;
			cpuPkg::opDiv:    fn[cpuPkg::fnDiv] = 1'b1;
			cpuPkg::opAnd:    fn[cpuPkg::fnAnd] = 1'b1;
			cpuPkg::opOr:     fn[cpuPkg::fnOr] = 1'b1;
			cpuPkg::opNotMem: fn[cpuPkg::fnNotMem] = 1'b1;
			cpuPkg::opShr:    fn[cpuPkg::fnShr] = 1'b1;
			cpuPkg::opShl:    fn[cpuPkg::fnShl] = 1'b1;
			cpuPkg::opNotAcc: fn[cpuPkg::fnNotAcc] = 1'b1;
			default:          fn = '0;
		endcase
		last = ctrlBit(cpuPkg::cBrToAlu) | ctrlBit(cpuPkg::cAluToAcc);
		if (op != cpuPkg::opNotMem)
			last |= ctrlBit(cpuPkg::cAccToAlu);
		case (op)
			cpuPkg::opStore:
			begin
				expQ.push_back('{ctrlBit(cpuPkg::cMarFromIr), '0});
				expQ.push_back('{ctrlBit(cpuPkg::cAccToMbr), '0});
				expQ.push_back('{ctrlBit(cpuPkg::cMbrToMem), '0});
			end
			cpuPkg::opLoad:
			begin
				expQ.push_back('{ctrlBit(cpuPkg::cMarFromIr), '0});
				expQ.push_back('{ctrlBit(cpuPkg::cMemToMbr), '0});
				expQ.push_back('{ctrlBit(cpuPkg::cMbrToAcc), '0});
			end
			cpuPkg::opAdd, cpuPkg::opSub, cpuPkg::opMul, cpuPkg::opDiv,
			cpuPkg::opAnd, cpuPkg::opOr, cpuPkg::opNotMem:
			begin
				expQ.push_back('{ctrlBit(cpuPkg::cMarFromIr), '0});
				expQ.push_back('{ctrlBit(cpuPkg::cMemToMbr), '0});
				expQ.push_back('{ctrlBit(cpuPkg::cBrFromMbr), '0});
				expQ.push_back('{last, fn});
			end
			cpuPkg::opShr, cpuPkg::opShl, cpuPkg::opNotAcc:
				expQ.push_back('{ctrlBit(cpuPkg::cAccToAlu) | ctrlBit(cpuPkg::cAluToAcc), fn});
			cpuPkg::opJump:
				expQ.push_back('{ctrlBit(cpuPkg::cPcFromIr), '0});
			cpuPkg::opJumpIfPos:
				if (!sign)
					expQ.push_back('{ctrlBit(cpuPkg::cPcFromIr), '0});
			default:
				fn = '0; // Halt and undefined codes execute nothing
		endcase
	endtask

	initial
	begin
		errCount = 0;
		wordCount = 0;
		prevRst = 1'b0;
	end

	always @(posedge clk)
	begin
		if (rst)
		begin
			prevCtrl <= '0;
			prevOpReq <= 1'b0;
			prevHalted <= 1'b0;
			prevRst <= 1'b1;
			seenHalt <= 1'b0;
			expQ.delete();
		end
		else
		begin
			if (prevRst)
				assert (ctrl == '0 && aluFn == '0 && !opReq && !halted)
				else failValue("ctrl,aluFn,opReq,halted", 0, {ctrl, aluFn, opReq, halted});
			for (int n = 0; n < 3; n++)
			begin
				if (prevCtrl == fetchWord(n))
					assert (ctrl == fetchWord(n + 1))
					else failValue("ctrl", fetchWord(n + 1), ctrl);
				// Each later fetch word needs its predecessor
				if (ctrl == fetchWord(n + 1) && prevCtrl != ctrl)
					assert (prevCtrl == fetchWord(n))
					else failValue("ctrl (previous cycle)", fetchWord(n), prevCtrl);
			end
			// Registered ctrl trails opReq by one cycle
			assert (ctrl[cpuPkg::cIrToCu] == prevOpReq)
			else failValue("ctrl[IrToCu]", prevOpReq, ctrl[cpuPkg::cIrToCu]);

			if (ctrl == fetchWord(0))
			begin
				assert (expQ.size() == 0)
				else failMsg($sformatf("%0d execute words missing before fetch", expQ.size()));
				assert (aluFn == '0) else failValue("aluFn", 0, aluFn);
				expQ.delete();
			end
			else if (ctrl != '0 && ctrl != fetchWord(1) && ctrl != fetchWord(2)
				&& ctrl != fetchWord(3))
			begin
				if (expQ.size() != 0)
					want = expQ.pop_front();
				else
					want = '0;
				wordCount++;
				assert (ctrl == want.ctrl) else failValue("ctrl", want.ctrl, ctrl);
				assert (aluFn == want.fn) else failValue("aluFn", want.fn, aluFn);
			end
			else
				assert (aluFn == '0) else failValue("aluFn", 0, aluFn);

			if (opReq && opAck) // Opcode latched by the DUT here
			begin
				expectExec(opcode, flags[cpuPkg::flagSign]);
				seenHalt <= (opcode == cpuPkg::opHalt);
			end
			if (prevHalted)
				assert (halted && !opReq && ctrl == '0)
				else failValue("halted,opReq,ctrl", {1'b1, 1'b0, 16'h0}, {halted, opReq, ctrl});
			if (halted && !prevHalted)
				assert (seenHalt) else failMsg("halted rose without an opHalt");

			prevCtrl <= ctrl;
			prevOpReq <= opReq;
			prevHalted <= halted;
			prevRst <= 1'b0;
		end
	end

	assert property (@(posedge clk) disable iff (rst) $rose(opReq) |-> !opAck)
	else failMsg("opReq rose while opAck was high");

	assert property (@(posedge clk) disable iff (rst) opReq && !opAck |=> opReq)
	else failMsg("opReq fell before opAck was seen high");

endmodule

//--- hw/controlUnit.sv
`timescale 1ns/1ps

module controlUnit (
	input  logic              clk,
	input  logic              rst,
	input  cpuPkg::opcode_t   opcode,
	input  logic              opAck,
	input  cpuPkg::flags_t    flags,
	output cpuPkg::ctrlWord_t ctrl,
	output cpuPkg::aluFn_t    aluFn,
	output logic              opReq,
	output logic              halted
);

	cuPkg::seqState_t seqState;
	cuPkg::decodedInstr_t decoded;
	logic opLatch;

	cuSequencer cuSequencer_i (
		.clk      (clk),
		.rst      (rst),
		.opAck    (opAck),
		.decoded  (decoded),
		.seqState (seqState),
		.opLatch  (opLatch),
		.opReq    (opReq),
		.halted   (halted)
	);

	// Instruction register
	opDecoder opDecoder_i (
		.clk     (clk),
		.rst     (rst),
		.opcode  (opcode),
		.opLatch (opLatch),
		.decoded (decoded)
	);

	ctrlWordGen ctrlWordGen_i (
		.clk      (clk),
		.rst      (rst),
		.seqState (seqState),
		.decoded  (decoded),
		.flags    (flags),
		.ctrl     (ctrl),
		.aluFn    (aluFn)
	);

endmodule

//--- hw/ctrlWordGen.sv
`timescale 1ns/1ps

module ctrlWordGen (
	input  logic                 clk,
	input  logic                 rst,
	input  cuPkg::seqState_t     seqState,
	input  cuPkg::decodedInstr_t decoded,
	input  cpuPkg::flags_t       flags,
	output cpuPkg::ctrlWord_t    ctrl,
	output cpuPkg::aluFn_t       aluFn
);

	cpuPkg::ctrlWord_t ctrlNext;
	cpuPkg::aluFn_t aluFnNext;
	logic lastStep;
	logic accOnly; // Shifts and NOT ACC

	assign lastStep = (seqState.step == decoded.len);
	assign accOnly = (decoded.cls == cuPkg::clsAluUnary) && (decoded.len == cuPkg::step_t'(1));

	always_comb
	begin
		ctrlNext = '0;
		aluFnNext = '0;
		case (seqState.phase)
			cuPkg::phF0:
				ctrlNext[cpuPkg::cMarFromPc] = 1'b1;
			cuPkg::phF1:
			begin
				ctrlNext[cpuPkg::cMbrRead] = 1'b1;
				ctrlNext[cpuPkg::cMemToMbr] = 1'b1;
				ctrlNext[cpuPkg::cPcInc] = 1'b1;
			end
			cuPkg::phF2:
				ctrlNext[cpuPkg::cIrFromMbr] = 1'b1;
			cuPkg::phReq:
				ctrlNext[cpuPkg::cIrToCu] = 1'b1; // Held while waiting on ack
			cuPkg::phExec:
			begin
				case (decoded.cls)
					cuPkg::clsStore:
						case (seqState.step)
							3'd1:    ctrlNext[cpuPkg::cMarFromIr] = 1'b1;
							3'd2:    ctrlNext[cpuPkg::cAccToMbr] = 1'b1;
							default: ctrlNext[cpuPkg::cMbrToMem] = 1'b1;
						endcase
					cuPkg::clsLoad:
						case (seqState.step)
							3'd1:    ctrlNext[cpuPkg::cMarFromIr] = 1'b1;
							3'd2:    ctrlNext[cpuPkg::cMemToMbr] = 1'b1;
							default: ctrlNext[cpuPkg::cMbrToAcc] = 1'b1;
						endcase
					cuPkg::clsAluMem, cuPkg::clsAluUnary:
					begin
						if (accOnly)
						begin
							ctrlNext[cpuPkg::cAccToAlu] = 1'b1;
							ctrlNext[cpuPkg::cAluToAcc] = 1'b1;
						end
						else
							case (seqState.step)
								3'd1: ctrlNext[cpuPkg::cMarFromIr] = 1'b1;
								3'd2: ctrlNext[cpuPkg::cMemToMbr] = 1'b1;
								3'd3: ctrlNext[cpuPkg::cBrFromMbr] = 1'b1;
								default:
								begin
									ctrlNext[cpuPkg::cBrToAlu] = 1'b1;
									ctrlNext[cpuPkg::cAluToAcc] = 1'b1;
									// NOT [X] uses the BR operand only
									ctrlNext[cpuPkg::cAccToAlu] = (decoded.cls == cuPkg::clsAluMem);
								end
							endcase
						if (lastStep)
							aluFnNext = decoded.fnCode;
					end
					cuPkg::clsJump:
						ctrlNext[cpuPkg::cPcFromIr] = 1'b1;
					cuPkg::clsJumpIfPos:
						ctrlNext[cpuPkg::cPcFromIr] = !flags[cpuPkg::flagSign]; // PC already advanced
					default:
						ctrlNext = '0;
				endcase
			end
			default:
				ctrlNext = '0; // Ack low and halt
		endcase
	end

	always_ff @(posedge clk or posedge rst)
	begin
		if (rst)
		begin
			ctrl <= '0;
			aluFn <= '0;
		end
		else
		begin
			ctrl <= ctrlNext;
			aluFn <= aluFnNext;
		end
	end

endmodule

//--- hw/opDecoder.sv
`timescale 1ns/1ps

module opDecoder (
	input  logic                 clk,
	input  logic                 rst,
	input  cpuPkg::opcode_t      opcode,
	input  logic                 opLatch,
	output cuPkg::decodedInstr_t decoded
);

	cuPkg::decodedInstr_t decodedNext;

	function automatic cpuPkg::aluFn_t fnBit(input int idx);
		cpuPkg::aluFn_t fn;
		fn = '0;
		fn[idx] = 1'b1;
		return fn;
	endfunction

	// Class and execute length
	always_comb
	begin
		decodedNext.cls = cuPkg::clsNop;
		decodedNext.len = '0;
		case (opcode)
			cpuPkg::opStore:
			begin
				decodedNext.cls = cuPkg::clsStore;
				decodedNext.len = cuPkg::step_t'(3);
			end
			cpuPkg::opLoad:
			begin
				decodedNext.cls = cuPkg::clsLoad;
				decodedNext.len = cuPkg::step_t'(3);
			end
			cpuPkg::opAdd, cpuPkg::opSub, cpuPkg::opMul,
			cpuPkg::opDiv, cpuPkg::opAnd, cpuPkg::opOr:
			begin
				decodedNext.cls = cuPkg::clsAluMem;
				decodedNext.len = cuPkg::step_t'(4);
			end
			cpuPkg::opNotMem:
			begin
				decodedNext.cls = cuPkg::clsAluUnary;
				decodedNext.len = cuPkg::step_t'(4); // Needs the operand fetch
			end
			cpuPkg::opShr, cpuPkg::opShl, cpuPkg::opNotAcc:
			begin
				decodedNext.cls = cuPkg::clsAluUnary;
				decodedNext.len = cuPkg::step_t'(1);
			end
			cpuPkg::opJump:
			begin
				decodedNext.cls = cuPkg::clsJump;
				decodedNext.len = cuPkg::step_t'(1);
			end
			cpuPkg::opJumpIfPos:
			begin
				decodedNext.cls = cuPkg::clsJumpIfPos;
				decodedNext.len = cuPkg::step_t'(1);
			end
			cpuPkg::opHalt:
				decodedNext.cls = cuPkg::clsHalt;
			default:
				decodedNext.cls = cuPkg::clsNop; // Undefined code
		endcase

		case (opcode)
			cpuPkg::opAdd:    decodedNext.fnCode = fnBit(cpuPkg::fnAdd);
			cpuPkg::opSub:    decodedNext.fnCode = fnBit(cpuPkg::fnSub);
			cpuPkg::opMul:    decodedNext.fnCode = fnBit(cpuPkg::fnMul);
			cpuPkg::opDiv:    decodedNext.fnCode = fnBit(cpuPkg::fnDiv);
			cpuPkg::opAnd:    decodedNext.fnCode = fnBit(cpuPkg::fnAnd);
			cpuPkg::opOr:     decodedNext.fnCode = fnBit(cpuPkg::fnOr);
			cpuPkg::opNotMem: decodedNext.fnCode = fnBit(cpuPkg::fnNotMem);
			cpuPkg::opShr:    decodedNext.fnCode = fnBit(cpuPkg::fnShr);
			cpuPkg::opShl:    decodedNext.fnCode = fnBit(cpuPkg::fnShl);
			cpuPkg::opNotAcc: decodedNext.fnCode = fnBit(cpuPkg::fnNotAcc);
			default:          decodedNext.fnCode = '0;
		endcase
	end

	always_ff @(posedge clk or posedge rst)
	begin
		if (rst)
			decoded <= '{cls: cuPkg::clsNop, len: '0, fnCode: '0};
		else if (opLatch)
			decoded <= decodedNext;
	end

endmodule

//--- hw/cuSequencer.sv
`timescale 1ns/1ps

module cuSequencer (
	input  logic                 clk,
	input  logic                 rst,
	input  logic                 opAck,
	input  cuPkg::decodedInstr_t decoded,
	output cuPkg::seqState_t     seqState,
	output logic                 opLatch,
	output logic                 opReq,
	output logic                 halted
);

	cuPkg::phase_t phase;
	cuPkg::phase_t phaseNext;
	cuPkg::step_t step;
	cuPkg::step_t stepNext;

	always_comb
	begin
		phaseNext = phase;
		stepNext = step;
		case (phase)
			cuPkg::phF0:
				phaseNext = cuPkg::phF1;
			cuPkg::phF1:
				phaseNext = cuPkg::phF2;
			cuPkg::phF2:
				phaseNext = cuPkg::phReq;
			cuPkg::phReq:
			begin
				if (opAck)
					phaseNext = cuPkg::phAckLow; // Opcode captured this cycle
			end
			cuPkg::phAckLow:
			begin
				if (!opAck)
				begin
					if (decoded.cls == cuPkg::clsHalt)
						phaseNext = cuPkg::phHalt;
					else if (decoded.len == '0)
						phaseNext = cuPkg::phF0; // Nothing to execute
					else
					begin
						phaseNext = cuPkg::phExec;
						stepNext = cuPkg::step_t'(1);
					end
				end
			end
			cuPkg::phExec:
			begin
				if (step == decoded.len)
				begin
					phaseNext = cuPkg::phF0;
					stepNext = '0;
				end
				else
					stepNext = step + 1'b1;
			end
			cuPkg::phHalt:
				phaseNext = cuPkg::phHalt; // Only reset leaves
			default:
			begin
				phaseNext = cuPkg::phF0;
				stepNext = '0;
			end
		endcase
	end

	always_ff @(posedge clk or posedge rst)
	begin
		if (rst)
		begin
			phase <= cuPkg::phF0;
			step <= '0;
		end
		else
		begin
			phase <= phaseNext;
			step <= stepNext;
		end
	end

	assign seqState = '{phase: phase, step: step};
	assign opReq = (phase == cuPkg::phReq);
	assign opLatch = (phase == cuPkg::phReq) && opAck; // First cycle ack is seen
	assign halted = (phase == cuPkg::phHalt);

endmodule

//--- hw/cuPkg.sv
package cuPkg;

	typedef logic [2:0] step_t; // Execute step, counts from 1

	typedef enum logic [2:0] {
		phF0,
		phF1,
		phF2,
		phReq,
		phAckLow,
		phExec,
		phHalt
	} phase_t;

	typedef enum logic [2:0] {
		clsStore,
		clsLoad,
		clsAluMem,
		clsAluUnary,
		clsJump,
		clsJumpIfPos,
		clsHalt,
		clsNop
	} instrClass_t;

	typedef struct packed {
		instrClass_t cls;
		step_t len; // Number of execute steps
		cpuPkg::aluFn_t fnCode;
	} decodedInstr_t;

	typedef struct packed {
		phase_t phase;
		step_t step;
	} seqState_t;

endpackage

//--- hw/cpuPkg.sv
package cpuPkg;

	typedef logic [15:0] ctrlWord_t; // One bit per register transfer
	typedef logic [10:0] aluFn_t; // One-hot ALU function
	typedef logic [7:0] opcode_t;
	typedef logic [7:0] flags_t;

	// Register control bit positions, C1 unused
	localparam int cMbrRead   = 0;
	localparam int cMarFromPc = 2;
	localparam int cPcFromIr  = 3;
	localparam int cIrFromMbr = 4;
	localparam int cMemToMbr  = 5;
	localparam int cBrFromMbr = 6;
	localparam int cAccToAlu  = 7;
	localparam int cMarFromIr = 8;
	localparam int cAluToAcc  = 9;
	localparam int cMbrToAcc  = 10;
	localparam int cAccToMbr  = 11;
	localparam int cMbrToMem  = 12;
	localparam int cIrToCu    = 13;
	localparam int cBrToAlu   = 14;
	localparam int cPcInc     = 15;

	localparam int fnAdd    = 1;
	localparam int fnSub    = 2;
	localparam int fnMul    = 3;
	localparam int fnDiv    = 4;
	localparam int fnAnd    = 5;
	localparam int fnOr     = 6;
	localparam int fnNotMem = 7;
	localparam int fnShr    = 8;
	localparam int fnShl    = 9;
	localparam int fnNotAcc = 10;

	localparam opcode_t opStore     = 8'd1;
	localparam opcode_t opLoad      = 8'd2;
	localparam opcode_t opAdd       = 8'd3;
	localparam opcode_t opSub       = 8'd4;
	localparam opcode_t opJumpIfPos = 8'd5; // Taken when ACC >= 0
	localparam opcode_t opJump      = 8'd6;
	localparam opcode_t opHalt      = 8'd7;
	localparam opcode_t opMul       = 8'd8;
	localparam opcode_t opDiv       = 8'd9;
	localparam opcode_t opAnd       = 8'd10;
	localparam opcode_t opOr        = 8'd11;
	localparam opcode_t opNotMem    = 8'd12;
	localparam opcode_t opShr       = 8'd13;
	localparam opcode_t opShl       = 8'd14;
	localparam opcode_t opNotAcc    = 8'd15;

	localparam int flagSign = 7; // ACC sign bit

endpackage
